//--- rtl/rv_pkg.sv
package rv_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  localparam logic [xlen-1:0] reset_pc    = 32'h0000_0000;
  localparam logic [xlen-1:0] ebreak_inst = 32'h0010_0073;

  // decode maps every rv32i instruction onto one of these execute opcodes
  typedef enum logic [3:0] {
    op_add,
    op_sub,
    op_and,
    op_or,
    op_xor,
    op_slt,
    op_sltu,
    op_sll,
    op_srl,
    op_sra,
    op_load,
    op_store,
    op_halt
  } op_e;

  // rv32i major opcodes in inst[6:0]
  typedef enum logic [6:0] {
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_branch = 7'b1100011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_op_imm = 7'b0010011,
    opc_op     = 7'b0110011,
    opc_system = 7'b1110011
  } rv_opc_e;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] inst;
  } fetch_t;

  typedef struct packed {
    logic [xlen-1:0]       pc;
    op_e                   op;
    logic [xlen-1:0]       val_a;
    logic [xlen-1:0]       val_b;
    logic [xlen-1:0]       val_c;  // store data
    logic [reg_addr_w-1:0] rd;
  } decode_t;

  typedef struct packed {
    logic [xlen-1:0]       pc;
    logic [reg_addr_w-1:0] rd;     // zero for stores, branches and halt
    logic [xlen-1:0]       wdata;
    logic                  halt;
  } exec_t;

endpackage

//--- rtl/gpr.sv
module gpr import rv_pkg::*; (
  input  logic                  clock,
  input  logic                  rst_n,
  input  logic [reg_addr_w-1:0] raddr1,
  input  logic [reg_addr_w-1:0] raddr2,
  output logic [xlen-1:0]       rdata1,
  output logic [xlen-1:0]       rdata2,
  input  logic                  wen,
  input  logic [reg_addr_w-1:0] waddr,
  input  logic [xlen-1:0]       wdata
);

  logic [xlen-1:0] regs [2**reg_addr_w];

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 2**reg_addr_w; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && waddr != '0) begin  // x0 stays zero
      regs[waddr] <= wdata;
    end
  end

  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];

endmodule

//--- rtl/ifu.sv
module ifu import rv_pkg::*; (
  input  logic            clock,
  input  logic            rst_n,
  output logic            imem_req,
  output logic [xlen-1:0] imem_addr,
  input  logic            imem_rvalid,
  input  logic [xlen-1:0] imem_rdata,
  input  logic            jump_flush,
  input  logic [xlen-1:0] jump_dnpc,
  input  logic            stop,
  output logic            out_valid,
  input  logic            out_ready,
  output fetch_t          out
);

  logic [xlen-1:0] pc;       // address of the word being or to be fetched
  logic            run;      // first fetch goes out one cycle after reset
  logic            pending;  // one fetch outstanding
  logic            drop;     // outstanding response belongs to a flushed path
  logic            issue;
  logic            resp_ok;

  assign issue     = run && !stop && !jump_flush && !pending && (!out_valid || out_ready);
  assign imem_req  = issue;
  assign imem_addr = pc;
  assign resp_ok   = imem_rvalid && !drop && !jump_flush;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      pc        <= reset_pc;
      run       <= 1'b0;
      pending   <= 1'b0;
      drop      <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      run <= 1'b1;
      if (issue) begin
        pending <= 1'b1;
      end else if (imem_rvalid) begin
        pending <= 1'b0;
      end
      if (jump_flush) begin
        drop <= pending && !imem_rvalid;  // response still to come
      end else if (imem_rvalid) begin
        drop <= 1'b0;
      end
      if (jump_flush) begin
        pc <= jump_dnpc;
      end else if (resp_ok) begin
        pc <= pc + 32'd4;
      end
      if (jump_flush) begin
        out_valid <= 1'b0;
      end else if (resp_ok) begin
        out_valid <= 1'b1;
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (resp_ok) begin
      out.pc   <= pc;
      out.inst <= imem_rdata;
    end
  end

endmodule

//--- rtl/idu.sv
module idu import rv_pkg::*; (
  input  logic                  clock,
  input  logic                  rst_n,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  fetch_t                in,
  output logic [reg_addr_w-1:0] rs1,
  output logic [reg_addr_w-1:0] rs2,
  input  logic [xlen-1:0]       src1,
  input  logic [xlen-1:0]       src2,
  input  logic [reg_addr_w-1:0] ex_rd,
  input  logic [reg_addr_w-1:0] wb_rd,
  output logic                  jump_flush,
  output logic [xlen-1:0]       jump_dnpc,
  output logic                  stop,
  output logic                  out_valid,
  input  logic                  out_ready,
  output decode_t               out
);

  logic [xlen-1:0]       inst;
  logic [reg_addr_w-1:0] rd;
  logic [2:0]            funct3;
  logic [xlen-1:0]       imm_i, imm_s, imm_b, imm_u, imm_j;
  logic [xlen-1:0]       jalr_sum;
  logic                  use1, use2;
  logic                  br_taken;
  logic                  redirect;
  logic [xlen-1:0]       target;
  logic                  is_halt;
  logic                  hazard;
  logic                  accept;
  decode_t               dec;

  function automatic op_e alu_op(input logic [2:0] f3, input logic alt, input logic is_reg);
    case (f3)
      3'b000:  alu_op = (alt && is_reg) ? op_sub : op_add;
      3'b001:  alu_op = op_sll;
      3'b010:  alu_op = op_slt;
      3'b011:  alu_op = op_sltu;
      3'b100:  alu_op = op_xor;
      3'b101:  alu_op = alt ? op_sra : op_srl;
      3'b110:  alu_op = op_or;
      default: alu_op = op_and;
    endcase
  endfunction

  function automatic logic clash(input logic [reg_addr_w-1:0] rs,
                                 input logic [reg_addr_w-1:0] busy_rd);
    clash = (busy_rd != '0) && (rs == busy_rd);
  endfunction

  assign inst   = in.inst;
  assign rd     = inst[11:7];
  assign funct3 = inst[14:12];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  assign jalr_sum = src1 + imm_i;

  always_comb begin
    case (funct3)
      3'b000:  br_taken = src1 == src2;
      3'b001:  br_taken = src1 != src2;
      3'b100:  br_taken = $signed(src1) < $signed(src2);
      3'b101:  br_taken = $signed(src1) >= $signed(src2);
      3'b110:  br_taken = src1 < src2;
      3'b111:  br_taken = src1 >= src2;
      default: br_taken = 1'b0;
    endcase
  end

  always_comb begin
    dec       = '0;
    dec.pc    = in.pc;
    dec.op    = op_add;
    dec.rd    = rd;
    use1      = 1'b0;
    use2      = 1'b0;
    redirect  = 1'b0;
    target    = in.pc + imm_b;
    is_halt   = 1'b0;
    case (inst[6:0])
      opc_lui: begin
        dec.val_b = imm_u;
      end
      opc_auipc: begin
        dec.val_a = in.pc;
        dec.val_b = imm_u;
      end
      opc_jal: begin
        dec.val_a = in.pc;
        dec.val_b = 32'd4;  // link value
        redirect  = 1'b1;
        target    = in.pc + imm_j;
      end
      opc_jalr: begin
        use1      = 1'b1;
        dec.val_a = in.pc;
        dec.val_b = 32'd4;
        redirect  = 1'b1;
        target    = {jalr_sum[xlen-1:1], 1'b0};
      end
      opc_branch: begin
        use1      = 1'b1;
        use2      = 1'b1;
        dec.val_a = in.pc;
        dec.val_b = 32'd4;
        dec.rd    = '0;
        redirect  = br_taken;
      end
      opc_load: begin
        use1      = funct3 == 3'b010;
        dec.op    = (funct3 == 3'b010) ? op_load : op_add;
        dec.val_a = src1;
        dec.val_b = imm_i;
        if (funct3 != 3'b010) begin
          dec = '{pc: in.pc, op: op_add, default: '0};  // only lw is kept
        end
      end
      opc_store: begin
        use1      = 1'b1;
        use2      = 1'b1;
        dec.op    = (funct3 == 3'b010) ? op_store : op_add;
        dec.val_a = src1;
        dec.val_b = imm_s;
        dec.val_c = src2;
        dec.rd    = '0;
      end
      opc_op_imm: begin
        use1      = 1'b1;
        dec.op    = alu_op(funct3, inst[30], 1'b0);
        dec.val_a = src1;
        dec.val_b = imm_i;  // shifts only look at the low 5 bits
      end
      opc_op: begin
        use1      = 1'b1;
        use2      = 1'b1;
        dec.op    = alu_op(funct3, inst[30], 1'b1);
        dec.val_a = src1;
        dec.val_b = src2;
      end
      opc_system: begin
        dec.rd = '0;
        if (inst == ebreak_inst) begin
          dec.op  = op_halt;
          is_halt = 1'b1;
        end
      end
      default: begin
        dec.rd = '0;  // undefined encoding decodes as a no-op
      end
    endcase
  end

  // sources must not be pending in our output register, exu or wbu
  assign hazard = (use1 && (clash(rs1, ex_rd) || clash(rs1, wb_rd) ||
                            (out_valid && clash(rs1, out.rd)))) ||
                  (use2 && (clash(rs2, ex_rd) || clash(rs2, wb_rd) ||
                            (out_valid && clash(rs2, out.rd))));

  assign in_ready = !stop && !jump_flush && !hazard && (!out_valid || out_ready);
  assign accept   = in_valid && in_ready;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      out_valid  <= 1'b0;
      jump_flush <= 1'b0;
      stop       <= 1'b0;
    end else begin
      if (accept) begin
        out_valid <= 1'b1;
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end
      jump_flush <= accept && redirect;
      if (accept && is_halt) begin
        stop <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      out <= dec;
    end
    if (accept && redirect) begin
      jump_dnpc <= target;
    end
  end

endmodule

//--- rtl/exu.sv
module exu import rv_pkg::*; (
  input  logic                  clock,
  input  logic                  rst_n,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  decode_t               in,
  output logic [reg_addr_w-1:0] ex_rd,
  output logic                  dmem_req,
  output logic                  dmem_we,
  output logic [xlen-1:0]       dmem_addr,
  output logic [xlen-1:0]       dmem_wdata,
  input  logic                  dmem_rvalid,
  input  logic [xlen-1:0]       dmem_rdata,
  output logic                  out_valid,
  input  logic                  out_ready,
  output exec_t                 out
);

  typedef enum logic {
    idle,
    wait_load
  } state_e;

  state_e                state;
  logic                  accept;
  logic                  is_load;
  logic                  is_store;
  logic                  load_done;
  logic [xlen-1:0]       sum;
  logic [xlen-1:0]       alu;
  logic [xlen-1:0]       ld_pc;
  logic [reg_addr_w-1:0] ld_rd;

  assign sum = in.val_a + in.val_b;

  always_comb begin
    case (in.op)
      op_sub:  alu = in.val_a - in.val_b;
      op_and:  alu = in.val_a & in.val_b;
      op_or:   alu = in.val_a | in.val_b;
      op_xor:  alu = in.val_a ^ in.val_b;
      op_slt:  alu = {{(xlen-1){1'b0}}, $signed(in.val_a) < $signed(in.val_b)};
      op_sltu: alu = {{(xlen-1){1'b0}}, in.val_a < in.val_b};
      op_sll:  alu = in.val_a << in.val_b[4:0];
      op_srl:  alu = in.val_a >> in.val_b[4:0];
      op_sra:  alu = $signed(in.val_a) >>> in.val_b[4:0];
      default: alu = sum;  // add and the load or store address
    endcase
  end

  assign in_ready  = (state == idle) && (!out_valid || out_ready);
  assign accept    = in_valid && in_ready;
  assign is_load   = in.op == op_load;
  assign is_store  = in.op == op_store;
  assign load_done = (state == wait_load) && dmem_rvalid;

  assign dmem_req   = accept && (is_load || is_store);
  assign dmem_we    = is_store;
  assign dmem_addr  = sum;
  assign dmem_wdata = in.val_c;

  assign ex_rd = (state == wait_load) ? ld_rd : (out_valid ? out.rd : '0);

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      state     <= idle;
      out_valid <= 1'b0;
    end else begin
      case (state)
        idle:      if (accept && is_load) state <= wait_load;
        wait_load: if (dmem_rvalid) state <= idle;
        default:   state <= idle;
      endcase
      if ((accept && !is_load) || load_done) begin
        out_valid <= 1'b1;
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (accept && is_load) begin
      ld_pc <= in.pc;
      ld_rd <= in.rd;
    end
    if (load_done) begin
      out.pc    <= ld_pc;
      out.rd    <= ld_rd;
      out.wdata <= (ld_rd == '0) ? '0 : dmem_rdata;
      out.halt  <= 1'b0;
    end else if (accept && !is_load) begin
      out.pc    <= in.pc;
      out.rd    <= in.rd;
      out.wdata <= (in.rd == '0) ? '0 : alu;  // retire reports what rd receives
      out.halt  <= in.op == op_halt;
    end
  end

endmodule

//--- rtl/wbu.sv
module wbu import rv_pkg::*; (
  input  logic                  clock,
  input  logic                  rst_n,
  input  logic                  in_valid,
  input  exec_t                 in,
  output logic [reg_addr_w-1:0] wb_rd,
  output logic                  gpr_wen,
  output logic [reg_addr_w-1:0] gpr_waddr,
  output logic [xlen-1:0]       gpr_wdata,
  output logic                  retire_valid,
  output logic [xlen-1:0]       retire_pc,
  output logic [reg_addr_w-1:0] retire_rd,
  output logic [xlen-1:0]       retire_wdata,
  output logic                  halt
);

  logic  valid;
  exec_t item;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      valid <= 1'b0;
      halt  <= 1'b0;
    end else begin
      valid <= in_valid;
      if (in_valid && in.halt) begin
        halt <= 1'b1;  // sticky and high together with the ebreak retire
      end
    end
  end

  always_ff @(posedge clock) begin
    if (in_valid) begin
      item <= in;
    end
  end

  assign wb_rd     = valid ? item.rd : '0;
  assign gpr_wen   = valid && (item.rd != '0);
  assign gpr_waddr = item.rd;
  assign gpr_wdata = item.wdata;

  assign retire_valid = valid;
  assign retire_pc    = item.pc;
  assign retire_rd    = item.rd;
  assign retire_wdata = item.wdata;

endmodule

//--- rtl/rv_core.sv
module rv_core import rv_pkg::*; (
  input  logic                  clock,
  input  logic                  rst_n,
  output logic                  imem_req,
  output logic [xlen-1:0]       imem_addr,
  input  logic                  imem_rvalid,
  input  logic [xlen-1:0]       imem_rdata,
  output logic                  dmem_req,
  output logic                  dmem_we,
  output logic [xlen-1:0]       dmem_addr,
  output logic [xlen-1:0]       dmem_wdata,
  input  logic                  dmem_rvalid,
  input  logic [xlen-1:0]       dmem_rdata,
  output logic                  retire_valid,
  output logic [xlen-1:0]       retire_pc,
  output logic [reg_addr_w-1:0] retire_rd,
  output logic [xlen-1:0]       retire_wdata,
  output logic                  halt
);

  logic [reg_addr_w-1:0] gpr_raddr1, gpr_raddr2;
  logic [xlen-1:0]       gpr_rdata1, gpr_rdata2;
  logic                  gpr_wen;
  logic [reg_addr_w-1:0] gpr_waddr;
  logic [xlen-1:0]       gpr_wdata;

  logic                  jump_flush;
  logic [xlen-1:0]       jump_dnpc;
  logic                  stop;
  logic [reg_addr_w-1:0] ex_rd, wb_rd;

  logic    ifu_out_valid, idu_in_ready;
  fetch_t  ifu_out;
  logic    idu_out_valid, exu_in_ready;
  decode_t idu_out;
  logic    exu_out_valid;
  exec_t   exu_out;

  gpr i_gpr (
    .clock(clock), .rst_n(rst_n),
    .raddr1(gpr_raddr1), .raddr2(gpr_raddr2),
    .rdata1(gpr_rdata1), .rdata2(gpr_rdata2),
    .wen(gpr_wen), .waddr(gpr_waddr), .wdata(gpr_wdata)
  );

  ifu i_ifu (
    .clock(clock), .rst_n(rst_n),
    .imem_req(imem_req), .imem_addr(imem_addr),
    .imem_rvalid(imem_rvalid), .imem_rdata(imem_rdata),
    .jump_flush(jump_flush), .jump_dnpc(jump_dnpc), .stop(stop),
    .out_valid(ifu_out_valid), .out_ready(idu_in_ready), .out(ifu_out)
  );

  idu i_idu (
    .clock(clock), .rst_n(rst_n),
    .in_valid(ifu_out_valid), .in_ready(idu_in_ready), .in(ifu_out),
    .rs1(gpr_raddr1), .rs2(gpr_raddr2), .src1(gpr_rdata1), .src2(gpr_rdata2),
    .ex_rd(ex_rd), .wb_rd(wb_rd),
    .jump_flush(jump_flush), .jump_dnpc(jump_dnpc), .stop(stop),
    .out_valid(idu_out_valid), .out_ready(exu_in_ready), .out(idu_out)
  );

  exu i_exu (
    .clock(clock), .rst_n(rst_n),
    .in_valid(idu_out_valid), .in_ready(exu_in_ready), .in(idu_out),
    .ex_rd(ex_rd),
    .dmem_req(dmem_req), .dmem_we(dmem_we),
    .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
    .dmem_rvalid(dmem_rvalid), .dmem_rdata(dmem_rdata),
    .out_valid(exu_out_valid), .out_ready(1'b1), .out(exu_out)  // wbu never stalls
  );

  wbu i_wbu (
    .clock(clock), .rst_n(rst_n),
    .in_valid(exu_out_valid), .in(exu_out),
    .wb_rd(wb_rd),
    .gpr_wen(gpr_wen), .gpr_waddr(gpr_waddr), .gpr_wdata(gpr_wdata),
    .retire_valid(retire_valid), .retire_pc(retire_pc),
    .retire_rd(retire_rd), .retire_wdata(retire_wdata),
    .halt(halt)
  );

endmodule

//--- dv/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

function automatic logic [31:0] r_op(input logic [6:0] f7, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3,
                                     input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, 7'h33};
endfunction

function automatic logic [31:0] i_op(input logic [11:0] imm, input logic [4:0] rs1,
                                     input logic [2:0] f3, input logic [4:0] rd,
                                     input logic [6:0] opc);
  return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] s_op(input logic [11:0] imm, input logic [4:0] rs2,
                                     input logic [4:0] rs1);
  return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
endfunction

function automatic logic [31:0] b_op(input logic [12:0] imm, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
endfunction

function automatic logic [31:0] j_op(input logic [20:0] imm, input logic [4:0] rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
endfunction

function void emit(input logic [31:0] inst);
  imem[prog_len] = inst;
  prog_len++;
endfunction

function logic [31:0] next_rand();
  rng_state = rng_state ^ (rng_state << 13);
  rng_state = rng_state ^ (rng_state >> 17);
  rng_state = rng_state ^ (rng_state << 5);
  return rng_state;
endfunction

function void clear_imem();
  for (int i = 0; i < 512; i++) begin
    imem[i] = {i[24:0], 7'b0};  // opcode 0 is an undefined no-op
  end
  prog_len = 0;
endfunction

function void init_dmem();
  for (int i = 0; i < 256; i++) begin
    dmem[i]     = (i * 32'h9e37_79b9) ^ 32'h0bad_0000;
    ref_dmem[i] = (i * 32'h9e37_79b9) ^ 32'h0bad_0000;
  end
endfunction

function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
  case (f3)
    3'd0: return alt ? a - b : a + b;
    3'd1: return a << b[4:0];
    3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'd3: return (a < b) ? 32'd1 : 32'd0;
    3'd4: return a ^ b;
    3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'd6: return a | b;
    default: return a & b;
  endcase
endfunction

// runs the program in imem on an architectural model and queues the retire records
function void ref_run();
  logic [31:0] x [32];
  logic [31:0] pc, npc, inst, res, a, b, imm_i, imm_s, imm_b, imm_u, imm_j;
  logic [4:0]  rd;
  logic [2:0]  f3;
  logic        taken, done;
  int          steps;
  for (int i = 0; i < 32; i++) x[i] = '0;
  pc = '0;
  done = 1'b0;
  steps = 0;
  while (!done && steps < 4000) begin
    inst  = imem[pc[10:2]];
    rd    = inst[11:7];
    f3    = inst[14:12];
    a     = x[inst[19:15]];
    b     = x[inst[24:20]];
    imm_i = {{20{inst[31]}}, inst[31:20]};
    imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    imm_u = {inst[31:12], 12'b0};
    imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    npc   = pc + 4;
    res   = '0;
    case (inst[6:0])
      7'h37: res = imm_u;
      7'h17: res = pc + imm_u;
      7'h6f: begin
        res = pc + 4;
        npc = pc + imm_j;
      end
      7'h67: begin
        res = pc + 4;
        npc = (a + imm_i) & ~32'd1;
      end
      7'h63: begin
        case (f3)
          3'd0: taken = a == b;
          3'd1: taken = a != b;
          3'd4: taken = $signed(a) < $signed(b);
          3'd5: taken = $signed(a) >= $signed(b);
          3'd6: taken = a < b;
          3'd7: taken = a >= b;
          default: taken = 1'b0;
        endcase
        if (taken) npc = pc + imm_b;
        rd = '0;
      end
      7'h03: begin
        if (f3 == 3'd2) res = ref_dmem[(a + imm_i) >> 2 & 32'hff];
        else rd = '0;
      end
      7'h23: begin
        if (f3 == 3'd2) ref_dmem[(a + imm_s) >> 2 & 32'hff] = b;
        rd = '0;
      end
      7'h13: res = alu_ref(f3, (f3 == 3'd5) && inst[30], a, imm_i);
      7'h33: res = alu_ref(f3, inst[30], a, b);
      default: begin
        rd = '0;  // system and undefined encodings
        done = inst == 32'h0010_0073;
      end
    endcase
    if (rd == '0) res = '0;
    else x[rd] = res;
    exp_pc.push_back(pc);
    exp_rd.push_back({27'b0, rd});
    exp_wd.push_back(res);
    pc = npc;
    steps++;
  end
endfunction

function void build_alu_prog();
  emit(i_op(12'hffb, 5'd0, 3'd0, 5'd1, 7'h13));   // x1 = -5
  emit({20'h80000, 5'd2, 7'h37});
  emit(i_op(12'h007, 5'd2, 3'd0, 5'd2, 7'h13));
  emit(i_op(12'd31, 5'd0, 3'd0, 5'd3, 7'h13));
  for (int f = 0; f < 8; f++) begin
    emit(r_op(7'h00, 5'd2, 5'd1, f[2:0], 5'(5 + f)));
  end
  emit(r_op(7'h20, 5'd2, 5'd1, 3'd0, 5'd13));     // sub
  emit(r_op(7'h20, 5'd3, 5'd2, 3'd5, 5'd14));     // sra by 31
  emit(r_op(7'h00, 5'd3, 5'd1, 3'd1, 5'd15));
  emit(r_op(7'h00, 5'd0, 5'd2, 3'd5, 5'd16));     // shift by 0
  emit(r_op(7'h00, 5'd1, 5'd2, 3'd3, 5'd17));
  emit(i_op(12'hf9c, 5'd1, 3'd0, 5'd18, 7'h13));
  emit(i_op(12'hf9c, 5'd1, 3'd2, 5'd19, 7'h13));
  emit(i_op(12'hf9c, 5'd1, 3'd3, 5'd20, 7'h13));
  emit(i_op(12'h5a5, 5'd2, 3'd4, 5'd21, 7'h13));
  emit(i_op(12'h0f0, 5'd1, 3'd6, 5'd22, 7'h13));
  emit(i_op(12'h0f0, 5'd1, 3'd7, 5'd23, 7'h13));
  emit(i_op(12'd31, 5'd1, 3'd1, 5'd24, 7'h13));
  emit(i_op(12'd0, 5'd2, 3'd5, 5'd25, 7'h13));
  emit(i_op(12'h41f, 5'd2, 3'd5, 5'd26, 7'h13));  // srai 31
  emit(i_op(12'd31, 5'd1, 3'd5, 5'd27, 7'h13));
  emit(32'h0010_0073);
endfunction

`endif

//--- dv/tb_rv_core.sv
module tb_rv_core;
  timeunit 1ns;
  timeprecision 1ps;

  logic        clock, rst_n;
  logic        imem_req, imem_rvalid, dmem_req, dmem_we, dmem_rvalid;
  logic [31:0] imem_addr, imem_rdata, dmem_addr, dmem_wdata, dmem_rdata;
  logic        retire_valid, halt;
  logic [31:0] retire_pc, retire_wdata;
  logic [4:0]  retire_rd;

  logic [31:0] imem [512];
  logic [31:0] dmem [256];
  logic [31:0] ref_dmem [256];
  logic [31:0] exp_pc[$], exp_rd[$], exp_wd[$];
  logic [31:0] rng_state = 32'hb133;
  logic        i_req_q, d_req_q;
  logic [31:0] i_addr_q, d_addr_q;
  int          prog_len, errors, retired, pass_cnt, fail_cnt;

  `include "tb_ref_model.svh"

  rv_core i_dut (.*);

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // both memories answer one cycle after the request
  always @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      i_req_q <= 1'b0;
      d_req_q <= 1'b0;
    end else begin
      i_req_q  <= imem_req;
      i_addr_q <= imem_addr;
      d_req_q  <= dmem_req && !dmem_we;
      d_addr_q <= dmem_addr;
      if (dmem_req && dmem_we) dmem[dmem_addr[9:2]] <= dmem_wdata;
    end
  end

  always @(negedge clock) begin
    imem_rvalid <= i_req_q;
    imem_rdata  <= imem[i_addr_q[10:2]];
    dmem_rvalid <= d_req_q;
    dmem_rdata  <= dmem[d_addr_q[9:2]];
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  always @(negedge clock) begin
    if (rst_n && retire_valid) begin
      retired++;
      if (exp_pc.size() == 0) begin
        $display("unexpected retire at %0t with pc %h", $time, retire_pc);
        errors++;
      end else begin
        check("retire_pc", retire_pc, exp_pc.pop_front());
        check("retire_rd", {27'b0, retire_rd}, exp_rd.pop_front());
        check("retire_wdata", retire_wdata, exp_wd.pop_front());
      end
    end
  end

  task automatic run_test(input string name);
    int limit, cycles, start_err, n_exp;
    start_err = errors;
    exp_pc.delete();
    exp_rd.delete();
    exp_wd.delete();
    init_dmem();
    ref_run();
    n_exp = exp_pc.size();
    limit = 12 * n_exp + 200;
    retired = 0;
    @(negedge clock);
    rst_n = 1'b0;
    repeat (5) @(negedge clock);
    rst_n = 1'b1;
    cycles = 0;
    while (!halt) begin
      @(negedge clock);
      cycles++;
      if (cycles > limit) begin
        $display("timeout: %s did not halt within %0d cycles", name, limit);
        $display("Test failed");
        $finish;
      end
    end
    repeat (20) begin
      @(negedge clock);
      check("halt", {31'b0, halt}, 32'd1);
    end
    check("retire count", retired, n_exp);
    for (int i = 0; i < 256; i++) begin
      check($sformatf("dmem[%0d]", i), dmem[i], ref_dmem[i]);
    end
    if (errors == start_err) begin
      pass_cnt++;
      $display("%s: pass, %0d instructions", name, n_exp);
    end else begin
      fail_cnt++;
      $display("%s: FAIL, %0d errors", name, errors - start_err);
    end
  endtask

  task automatic build_mem_prog();
    emit(i_op(12'h040, 5'd0, 3'd0, 5'd1, 7'h13));
    emit(i_op(12'h123, 5'd0, 3'd0, 5'd2, 7'h13));
    emit(s_op(12'd0, 5'd2, 5'd1));
    emit(i_op(12'd0, 5'd1, 3'd2, 5'd3, 7'h03));   // load right after store
    emit(i_op(12'd1, 5'd3, 3'd0, 5'd4, 7'h13));
    emit(s_op(12'd4, 5'd4, 5'd1));
    emit(i_op(12'd4, 5'd1, 3'd2, 5'd5, 7'h03));
    emit(r_op(7'h00, 5'd3, 5'd5, 3'd0, 5'd6));
    emit(i_op(12'd8, 5'd1, 3'd2, 5'd7, 7'h03));
    emit(i_op(12'd8, 5'd7, 3'd2, 5'd8, 7'h03));   // address from loaded data
    emit(s_op(12'd12, 5'd7, 5'd1));
    emit(s_op(12'd16, 5'd6, 5'd1));
    emit({20'habcde, 5'd5, 7'h37});                // lui
    emit({20'h00010, 5'd6, 7'h17});                // auipc
    emit(i_op(12'd5, 5'd0, 3'd0, 5'd0, 7'h13));    // write to x0
    emit(r_op(7'h00, 5'd6, 5'd5, 3'd0, 5'd0));
    emit(r_op(7'h00, 5'd5, 5'd0, 3'd0, 5'd9));
    emit(s_op(12'd20, 5'd0, 5'd1));
    emit(32'h0010_0073);
  endtask

  task automatic build_branch_prog();
    logic [2:0] conds [6];
    conds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    emit(i_op(12'hffd, 5'd0, 3'd0, 5'd1, 7'h13));
    emit(i_op(12'd5, 5'd0, 3'd0, 5'd2, 7'h13));
    emit(i_op(12'd5, 5'd0, 3'd0, 5'd3, 7'h13));
    for (int k = 0; k < 6; k++) begin
      emit(b_op(13'd8, 5'd2, 5'd1, conds[k]));     // unequal operands
      emit(i_op(12'd1, 5'd10, 3'd0, 5'd10, 7'h13));
      emit(b_op(13'd8, 5'd3, 5'd2, conds[k]));     // equal operands
      emit(i_op(12'd1, 5'd11, 3'd0, 5'd11, 7'h13));
      emit(b_op(13'd8, 5'd1, 5'd2, conds[k]));     // unequal operands swapped
      emit(i_op(12'd1, 5'd15, 3'd0, 5'd15, 7'h13));
    end
    emit(j_op(21'd8, 5'd12));
    emit(i_op(12'd1, 5'd10, 3'd0, 5'd10, 7'h13));
    emit({20'h0, 5'd13, 7'h17});
    emit(i_op(12'd16, 5'd13, 3'd0, 5'd13, 7'h13));
    emit(i_op(12'd0, 5'd13, 3'd0, 5'd14, 7'h67));  // jalr skips one
    emit(i_op(12'd1, 5'd11, 3'd0, 5'd11, 7'h13));
    emit(s_op(12'h100, 5'd10, 5'd0));
    emit(s_op(12'h104, 5'd11, 5'd0));
    emit(s_op(12'h108, 5'd15, 5'd0));
    emit(32'h0010_0073);
  endtask

  task automatic build_random_prog();
    logic [31:0] r;
    logic [2:0]  f3;
    logic [4:0]  rd, rs1, rs2;
    logic        alt;
    logic [2:0]  conds [6];
    conds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    for (int i = 0; i < 200; i++) begin
      r   = next_rand();
      rd  = 5'(1 + (r >> 3) % 7);
      rs1 = 5'((r >> 6) % 8);
      rs2 = 5'((r >> 9) % 8);
      f3  = r[14:12];
      alt = r[15] && (f3 == 3'd0 || f3 == 3'd5);
      case (r % 8)
        0, 1: emit(r_op(alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd));
        2, 3: begin
          if (f3 == 3'd1) emit(i_op({7'h00, r[20:16]}, rs1, f3, rd, 7'h13));
          else if (f3 == 3'd5) emit(i_op({r[15] ? 7'h20 : 7'h00, r[20:16]}, rs1, f3, rd, 7'h13));
          else emit(i_op(r[27:16], rs1, f3, rd, 7'h13));
        end
        4: emit(i_op(12'(32'h100 + ((r >> 16) % 64) * 4), 5'd0, 3'd2, rd, 7'h03));
        5: emit(s_op(12'(32'h100 + ((r >> 16) % 64) * 4), rs2, 5'd0));
        6: emit(b_op((i < 198) ? 13'(8 + 4 * r[16]) : 13'd4, rs2, rs1, conds[(r >> 20) % 6]));
        default: emit({r[31:12], rd, 7'h37});
      endcase
    end
    emit(32'h0010_0073);
  endtask

  initial begin
    rst_n = 1'b0;
    imem_rvalid = 1'b0;
    imem_rdata = '0;
    dmem_rvalid = 1'b0;
    dmem_rdata = '0;
    errors = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    clear_imem();
    build_alu_prog();
    run_test("alu and shifts");
    clear_imem();
    build_mem_prog();
    run_test("lui auipc x0 loads stores");
    clear_imem();
    build_branch_prog();
    run_test("branches and jumps");
    clear_imem();
    build_random_prog();
    run_test("random program with halt");
    $display("passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (errors == 0 && fail_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+dv
rtl/rv_pkg.sv
rtl/gpr.sv
rtl/ifu.sv
rtl/idu.sv
rtl/exu.sv
rtl/wbu.sv
rtl/rv_core.sv
dv/tb_rv_core.sv

//--- Makefile
TOOL  = verilator
FLAGS = --binary --timing -Wno-fatal
TOP   = tb_rv_core
FLIST = flist.f
LOG   = sim.log
BIN   = obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL), run, and search $(LOG) for the pass message"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./$(BIN) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
